/* logic/zx_bus_pkg.sv */
/*
 * Shared widths, vector types, port decode constants, configuration
 * mode enums and the packed bus, configuration, paging and RAM request
 * structs of the ZX Spectrum bus controller
 */
package zx_bus_pkg;

	// ============================================================
	// Widths and vector types
	// ============================================================
	localparam int ADDR_W     = 16;
	localparam int RAM_ADDR_W = 24;

	typedef logic [ADDR_W-1:0]     cpu_addr_t;
	typedef logic [7:0]            byte_t;
	typedef logic [RAM_ADDR_W-1:0] ram_addr_t;
	typedef logic [3:0]            rom_page_t;
	typedef logic [5:0]            ram_page_t;
	typedef logic [4:0]            key_row_t;   // Active low
	typedef logic [5:0]            joy_t;       // R, L, D, U, fire, fire 2 from bit 0
	typedef logic [2:0]            border_t;

	// ============================================================
	// Fixed values
	// ============================================================
	localparam logic [2:0] ROM_BASE      = 3'b101;  // ROM area starts at 1.25 MB
	localparam logic [5:0] PORT_KEMPSTON = 6'h1F;

	// EFF7 is A15..A13 high, A12 and A3 low
	localparam cpu_addr_t PORT_EFF7_MASK  = 16'hF008;
	localparam cpu_addr_t PORT_EFF7_MATCH = 16'hE000;

	// 1FFD is A15..A13 low, A12 high, A1 low
	localparam cpu_addr_t PORT_1FFD_MASK  = 16'hF002;
	localparam cpu_addr_t PORT_1FFD_MATCH = 16'h1000;

	localparam ram_page_t FIXED_PAGE_1 = 6'd5;  // Screen bank at 4000
	localparam ram_page_t FIXED_PAGE_2 = 6'd2;

	// ============================================================
	// Configuration modes
	// ============================================================
	typedef enum logic [1:0] {
		MEM_128,
		MEM_P1024,
		MEM_48,
		MEM_PLUS3
	} mem_mode_e;

	typedef enum logic [1:0] {
		JOY_SINCLAIR1,
		JOY_SINCLAIR2,
		JOY_KEMPSTON,
		JOY_CURSOR
	} joy_mode_e;

	// ============================================================
	// Structs
	// ============================================================
	typedef struct packed {
		cpu_addr_t addr;
		byte_t     dout;
		logic      mreq;
		logic      iorq;
		logic      rd;
		logic      wr;
		logic      m1;
	} cpu_bus_t;

	typedef struct packed {
		mem_mode_e mem_mode;
		joy_mode_e joy0_mode;
		joy_mode_e joy1_mode;
	} zx_cfg_t;

	typedef struct packed {
		logic       special;      // +3 all-RAM layout active
		logic [1:0] special_cfg;
		rom_page_t  rom_page;
		ram_page_t  ram_page;     // Bank seen at C000
	} page_state_t;

	typedef struct packed {
		ram_addr_t addr;
		logic      rd;
		logic      we;
	} ram_req_t;

endpackage

/* logic/zx_pager.sv */
/*
 * Memory paging registers 7FFD, 1FFD and EFF7 with their port decode,
 * Pentagon 1024 extended bank bits and the machine mode flags
 */
module zx_pager (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  zx_bus_pkg::cpu_bus_t   bus_i,
	input  zx_bus_pkg::mem_mode_e  mem_mode_i,
	output zx_bus_pkg::page_state_t page_o
);

	zx_bus_pkg::byte_t page_reg;        // 7FFD
	zx_bus_pkg::byte_t page_reg_plus3;  // 1FFD
	zx_bus_pkg::byte_t page_reg_p1024;  // EFF7
	logic [2:0]        page_ext;        // Pentagon bank bits above 7FFD[2:0]

	logic zx48;
	logic p1024;
	logic plus3;

	logic io_wr;
	logic io_wr_d;
	logic io_wr_edge;
	logic page_disable;
	logic page_write;
	logic page_write_plus3;
	logic page_write_p1024;

	zx_bus_pkg::rom_page_t rom_page;

	// ============================================================
	// Port decode
	// ============================================================
	assign io_wr      = bus_i.iorq & bus_i.wr & ~bus_i.m1;
	assign io_wr_edge = io_wr & ~io_wr_d;  // One write per bus cycle

	// Pentagon 1024 honours the 7FFD lock bit 5 only with EFF7[2] set
	assign page_disable = zx48 |
		(~p1024 & page_reg[5]) |
		(p1024 & page_reg_p1024[2] & page_reg[5]);

	assign page_write = ~bus_i.addr[15] & ~bus_i.addr[1] &
		(bus_i.addr[14] | ~plus3) & ~page_disable;

	assign page_write_plus3 = plus3 & ~page_disable &
		((bus_i.addr & zx_bus_pkg::PORT_1FFD_MASK) == zx_bus_pkg::PORT_1FFD_MATCH);

	assign page_write_p1024 = p1024 &
		((bus_i.addr & zx_bus_pkg::PORT_EFF7_MASK) == zx_bus_pkg::PORT_EFF7_MATCH);

	// ============================================================
	// Registers
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_d        <= 1'b0;
			page_reg       <= '0;
			page_reg_plus3 <= '0;
			page_reg_p1024 <= '0;
			page_ext       <= '0;
			zx48  <= (mem_mode_i == zx_bus_pkg::MEM_48);
			p1024 <= (mem_mode_i == zx_bus_pkg::MEM_P1024);
			plus3 <= (mem_mode_i == zx_bus_pkg::MEM_PLUS3);
		end else begin
			io_wr_d <= io_wr;
			if (io_wr_edge) begin
				if (page_write) begin
					page_reg <= bus_i.dout;
					if (p1024 & ~page_reg_p1024[2]) begin
						page_ext <= {bus_i.dout[5], bus_i.dout[7:6]};
					end
				end else if (page_write_plus3) begin
					page_reg_plus3 <= bus_i.dout;
				end
				if (page_write_p1024) page_reg_p1024 <= bus_i.dout;
			end
		end
	end

	// ROM bank per machine
	always_comb begin
		if (zx48) begin
			rom_page = 4'd15;
		end else if (plus3) begin
			rom_page = {2'b10, page_reg_plus3[2], page_reg[4]};  // Banks 8 to 11
		end else begin
			rom_page = {3'b011, page_reg[4]};  // 128K editor or 48 BASIC
		end
	end

	assign page_o.special     = page_reg_plus3[0];
	assign page_o.special_cfg = page_reg_plus3[2:1];
	assign page_o.rom_page    = rom_page;
	assign page_o.ram_page    = {page_ext, page_reg[2:0]};

endmodule

/* logic/zx_input_ports.sv */
/*
 * ULA port FE with the border, EAR and MIC latch on write, the keyboard
 * read byte with Sinclair and Cursor joystick mapping, and the Kempston byte
 */
module zx_input_ports (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  zx_bus_pkg::cpu_bus_t  bus_i,
	input  zx_bus_pkg::joy_mode_e joy0_mode_i,
	input  zx_bus_pkg::joy_mode_e joy1_mode_i,
	input  zx_bus_pkg::joy_t      joy0_i,
	input  zx_bus_pkg::joy_t      joy1_i,
	input  zx_bus_pkg::key_row_t  key_data_i,
	input  logic                  tape_in_i,
	output zx_bus_pkg::byte_t     ula_rd_o,
	output zx_bus_pkg::byte_t     kemp_rd_o,
	output zx_bus_pkg::border_t   border_o,
	output logic                  ear_o,
	output logic                  mic_o
);

	logic io_wr;
	logic io_wr_d;

	zx_bus_pkg::joy_t     joy_kempston;
	logic [4:0]           joy_sinclair1;
	logic [4:0]           joy_sinclair2;
	logic [4:0]           joy_cursor;
	zx_bus_pkg::key_row_t joy_kbd;

	// Sinclair joystick bits L, R, D, U and fire onto key bits 4 down to 0
	function automatic logic [4:0] sinclair_row(input logic [4:0] joy);
		sinclair_row = {joy[1], joy[0], joy[2], joy[3], joy[4]};
	endfunction

	// ============================================================
	// FE write latch
	// ============================================================
	assign io_wr = bus_i.iorq & bus_i.wr & ~bus_i.m1;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_d  <= 1'b0;
			border_o <= '0;
			ear_o    <= 1'b0;
			mic_o    <= 1'b0;
		end else begin
			io_wr_d <= io_wr;
			if (io_wr & ~io_wr_d & ~bus_i.addr[0]) begin
				border_o <= bus_i.dout[2:0];
				ear_o    <= bus_i.dout[4];
				mic_o    <= bus_i.dout[3];
			end
		end
	end

	// ============================================================
	// Joystick routing
	// ============================================================
	always_comb begin
		joy_kempston  = '0;
		joy_sinclair1 = '0;
		joy_sinclair2 = '0;
		joy_cursor    = '0;
		case (joy0_mode_i)
			zx_bus_pkg::JOY_SINCLAIR1: joy_sinclair1 |= joy0_i[4:0];
			zx_bus_pkg::JOY_SINCLAIR2: joy_sinclair2 |= joy0_i[4:0];
			zx_bus_pkg::JOY_KEMPSTON:  joy_kempston  |= joy0_i;
			default:                   joy_cursor    |= joy0_i[4:0];
		endcase
		case (joy1_mode_i)
			zx_bus_pkg::JOY_SINCLAIR1: joy_sinclair1 |= joy1_i[4:0];
			zx_bus_pkg::JOY_SINCLAIR2: joy_sinclair2 |= joy1_i[4:0];
			zx_bus_pkg::JOY_KEMPSTON:  joy_kempston  |= joy1_i;
			default:                   joy_cursor    |= joy1_i[4:0];
		endcase
	end

	// Row 6-0 (A12 low) and row 1-5 (A11 low)
	assign joy_kbd =
		({5{bus_i.addr[12]}} | ~(sinclair_row(joy_sinclair1) |
			{joy_cursor[2], joy_cursor[3], joy_cursor[0], 1'b0, joy_cursor[4]})) &
		({5{bus_i.addr[11]}} | ~(sinclair_row(joy_sinclair2) |
			{joy_cursor[1], 4'b0000}));

	assign ula_rd_o  = {1'b1, tape_in_i | ear_o, 1'b1, key_data_i & joy_kbd};
	assign kemp_rd_o = {2'b00, joy_kempston};

endmodule

/* logic/zx_bus_map.sv */
/*
 * CPU address to RAM address mapping for normal and +3 special modes,
 * ROM write protection and the CPU read-data multiplexer
 */
module zx_bus_map (
	input  zx_bus_pkg::cpu_bus_t    bus_i,
	input  zx_bus_pkg::page_state_t page_i,
	input  zx_bus_pkg::byte_t       ula_rd_i,
	input  zx_bus_pkg::byte_t       kemp_rd_i,
	input  zx_bus_pkg::byte_t       ram_dout_i,
	output zx_bus_pkg::ram_req_t    ram_o,
	output zx_bus_pkg::byte_t       cpu_din_o
);

	logic [1:0]            slot;
	logic [2:0]            special_bank;
	zx_bus_pkg::ram_page_t bank;

	assign slot = bus_i.addr[15:14];

	// +3 all-RAM layouts
	always_comb begin
		case (page_i.special_cfg)
			2'b00:   special_bank = {1'b0, slot};                      // 0 1 2 3
			2'b01:   special_bank = {1'b1, slot};                      // 4 5 6 7
			2'b10:   special_bank = (slot == 2'd3) ? 3'd3 : {1'b1, slot};  // 4 5 6 3
			default: special_bank = {~&slot, |slot, slot[0]};          // 4 7 6 3
		endcase
	end

	always_comb begin
		case (slot)
			2'd1:    bank = zx_bus_pkg::FIXED_PAGE_1;
			2'd2:    bank = zx_bus_pkg::FIXED_PAGE_2;
			default: bank = page_i.ram_page;
		endcase
		if (page_i.special) bank = {3'd0, special_bank};
	end

	// ============================================================
	// RAM request
	// ============================================================
	always_comb begin
		if (!page_i.special && slot == 2'd0) begin
			ram_o.addr = {3'd0, zx_bus_pkg::ROM_BASE, page_i.rom_page, bus_i.addr[13:0]};
		end else begin
			ram_o.addr = {4'd0, bank, bus_i.addr[13:0]};
		end
		ram_o.rd = bus_i.mreq & bus_i.rd;
		ram_o.we = bus_i.mreq & bus_i.wr &
			(bus_i.addr[15] | bus_i.addr[14] | page_i.special);  // No ROM writes
	end

	// ============================================================
	// CPU read data
	// ============================================================
	always_comb begin
		if (bus_i.mreq) begin
			cpu_din_o = ram_dout_i;
		end else if (bus_i.iorq & bus_i.rd & ~bus_i.m1) begin
			if (bus_i.addr[5:0] == zx_bus_pkg::PORT_KEMPSTON) begin
				cpu_din_o = kemp_rd_i;
			end else if (!bus_i.addr[0]) begin
				cpu_din_o = ula_rd_i;
			end else begin
				cpu_din_o = 8'hFF;  // Floating bus
			end
		end else begin
			cpu_din_o = 8'hFF;
		end
	end

endmodule

/* logic/zx_bus_ctrl.sv */
/*
 * Top level of the ZX Spectrum bus controller joining paging, the ULA
 * and joystick ports, and RAM address mapping
 */
module zx_bus_ctrl (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  zx_bus_pkg::cpu_bus_t bus_i,
	input  zx_bus_pkg::zx_cfg_t  cfg_i,       // Sampled during reset
	input  zx_bus_pkg::byte_t    ram_dout_i,
	input  zx_bus_pkg::key_row_t key_data_i,
	input  zx_bus_pkg::joy_t     joy0_i,
	input  zx_bus_pkg::joy_t     joy1_i,
	input  logic                 tape_in_i,
	output zx_bus_pkg::ram_req_t ram_o,
	output zx_bus_pkg::byte_t    cpu_din_o,
	output zx_bus_pkg::border_t  border_o,
	output logic                 ear_o,
	output logic                 mic_o
);

	zx_bus_pkg::page_state_t page;
	zx_bus_pkg::byte_t       ula_rd;
	zx_bus_pkg::byte_t       kemp_rd;

	zx_pager u_pager (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus_i      (bus_i),
		.mem_mode_i (cfg_i.mem_mode),
		.page_o     (page)
	);

	zx_input_ports u_ports (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.bus_i       (bus_i),
		.joy0_mode_i (cfg_i.joy0_mode),
		.joy1_mode_i (cfg_i.joy1_mode),
		.joy0_i      (joy0_i),
		.joy1_i      (joy1_i),
		.key_data_i  (key_data_i),
		.tape_in_i   (tape_in_i),
		.ula_rd_o    (ula_rd),
		.kemp_rd_o   (kemp_rd),
		.border_o    (border_o),
		.ear_o       (ear_o),
		.mic_o       (mic_o)
	);

	zx_bus_map u_map (
		.bus_i      (bus_i),
		.page_i     (page),
		.ula_rd_i   (ula_rd),
		.kemp_rd_i  (kemp_rd),
		.ram_dout_i (ram_dout_i),
		.ram_o      (ram_o),
		.cpu_din_o  (cpu_din_o)
	);

endmodule

/* bench/zx_clock_gen.sv */
/*
 * Testbench clock with a period of 100 and a reset that stays high
 * for 4 cycles at start and after each restart request
 */
module zx_clock_gen (
	input  logic reset_req_i,
	output logic clk_o,
	output logic reset_o
);

	int unsigned count;

	initial begin
		clk_o   = 1'b0;
		reset_o = 1'b1;
		count   = 4;
		forever #50 clk_o = ~clk_o;
	end

	always @(posedge clk_o) begin
		if (reset_req_i) begin
			count   <= 4;
			reset_o <= 1'b1;
		end else if (count > 1) begin
			count <= count - 1;
		end else begin
			count   <= 0;
			reset_o <= 1'b0;  // Released after the fourth reset cycle
		end
	end

endmodule

/* bench/zx_bus_ctrl_tb.sv */
/*
 * Directed testbench for the bus controller covering paging in 128K, 48K,
 * +3 and Pentagon 1024 modes, port FE with joysticks, the Kempston port
 * and the CPU read-data mux
 */
module zx_bus_ctrl_tb;

	localparam int RESET_TIMEOUT = 20;

	// Banks of slots 0 to 3 per +3 special layout
	localparam int SPECIAL_BANKS [4][4] = '{
		'{0, 1, 2, 3}, '{4, 5, 6, 7}, '{4, 5, 6, 3}, '{4, 7, 6, 3}};

	logic                   clk_sys;
	logic                   reset;
	logic                   reset_req;
	zx_bus_pkg::cpu_bus_t   bus;
	zx_bus_pkg::zx_cfg_t    cfg;
	zx_bus_pkg::byte_t      ram_dout;
	zx_bus_pkg::key_row_t   key_data;
	zx_bus_pkg::joy_t       joy0;
	zx_bus_pkg::joy_t       joy1;
	logic                   tape_in;
	zx_bus_pkg::ram_req_t   ram;
	zx_bus_pkg::byte_t      cpu_din;
	zx_bus_pkg::border_t    border;
	logic                   ear;
	logic                   mic;

	int   checks;
	int   errors;
	logic timed_out;

	zx_clock_gen u_clk (
		.reset_req_i (reset_req),
		.clk_o       (clk_sys),
		.reset_o     (reset)
	);

	zx_bus_ctrl u_dut (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus_i      (bus),
		.cfg_i      (cfg),
		.ram_dout_i (ram_dout),
		.key_data_i (key_data),
		.joy0_i     (joy0),
		.joy1_i     (joy1),
		.tape_in_i  (tape_in),
		.ram_o      (ram),
		.cpu_din_o  (cpu_din),
		.border_o   (border),
		.ear_o      (ear),
		.mic_o      (mic)
	);

	// ============================================================
	// Stimulus helpers and reference model
	// ============================================================
	function automatic zx_bus_pkg::cpu_bus_t bus_of(input zx_bus_pkg::cpu_addr_t addr,
		input zx_bus_pkg::byte_t dout, input logic mreq, input logic iorq,
		input logic rd, input logic wr);
		zx_bus_pkg::cpu_bus_t b;
		b.addr = addr;
		b.dout = dout;
		b.mreq = mreq;
		b.iorq = iorq;
		b.rd   = rd;
		b.wr   = wr;
		b.m1   = 1'b0;
		return b;
	endfunction

	function automatic zx_bus_pkg::zx_cfg_t cfg_of(input zx_bus_pkg::mem_mode_e mem,
		input zx_bus_pkg::joy_mode_e j0, input zx_bus_pkg::joy_mode_e j1);
		zx_bus_pkg::zx_cfg_t c;
		c.mem_mode  = mem;
		c.joy0_mode = j0;
		c.joy1_mode = j1;
		return c;
	endfunction

	// Bank times 16K plus the offset in the slot
	function automatic zx_bus_pkg::ram_addr_t bank_addr(input int bank,
		input zx_bus_pkg::cpu_addr_t addr);
		return zx_bus_pkg::ram_addr_t'(bank * 16384 + int'(addr[13:0]));
	endfunction

	function automatic zx_bus_pkg::ram_addr_t rom_addr(input int page,
		input zx_bus_pkg::cpu_addr_t addr);
		return zx_bus_pkg::ram_addr_t'(int'(zx_bus_pkg::ROM_BASE) * 262144 +
			page * 16384 + int'(addr[13:0]));
	endfunction

	// Pentagon bank with the extension from one 7FFD value and the low bits from another
	function automatic int ext_bank(input zx_bus_pkg::byte_t ext_src,
		input zx_bus_pkg::byte_t low_src);
		return int'(ext_src[5]) * 32 + int'(ext_src[7]) * 16 + int'(ext_src[6]) * 8 +
			int'(low_src[2:0]);
	endfunction

	function automatic zx_bus_pkg::joy_t joy_in_mode(input zx_bus_pkg::joy_mode_e m0,
		input zx_bus_pkg::joy_t j0, input zx_bus_pkg::joy_mode_e m1,
		input zx_bus_pkg::joy_t j1, input zx_bus_pkg::joy_mode_e mode);
		zx_bus_pkg::joy_t r;
		r = 6'd0;
		if (m0 == mode) r |= j0;
		if (m1 == mode) r |= j1;
		return r;
	endfunction

	function automatic zx_bus_pkg::byte_t fe_expected(input zx_bus_pkg::cpu_addr_t addr,
		input zx_bus_pkg::key_row_t keys, input zx_bus_pkg::joy_t j0,
		input zx_bus_pkg::joy_t j1, input zx_bus_pkg::joy_mode_e m0,
		input zx_bus_pkg::joy_mode_e m1, input logic tape_ear);
		zx_bus_pkg::joy_t s1;
		zx_bus_pkg::joy_t s2;
		zx_bus_pkg::joy_t cur;
		logic [4:0]       pull;
		s1   = joy_in_mode(m0, j0, m1, j1, zx_bus_pkg::JOY_SINCLAIR1);
		s2   = joy_in_mode(m0, j0, m1, j1, zx_bus_pkg::JOY_SINCLAIR2);
		cur  = joy_in_mode(m0, j0, m1, j1, zx_bus_pkg::JOY_CURSOR);
		pull = 5'd0;
		if (!addr[12]) begin
			if (s1[1] | cur[2]) pull[4] = 1'b1;  // Left, cursor down
			if (s1[0] | cur[3]) pull[3] = 1'b1;
			if (s1[2] | cur[0]) pull[2] = 1'b1;
			if (s1[3]) pull[1] = 1'b1;
			if (s1[4] | cur[4]) pull[0] = 1'b1;
		end
		if (!addr[11]) begin
			if (s2[1] | cur[1]) pull[4] = 1'b1;  // Left on both
			if (s2[0]) pull[3] = 1'b1;
			if (s2[2]) pull[2] = 1'b1;
			if (s2[3]) pull[1] = 1'b1;
			if (s2[4]) pull[0] = 1'b1;
		end
		return {1'b1, tape_ear, 1'b1, keys & ~pull};
	endfunction

	task automatic check_equal(input logic [23:0] got, input logic [23:0] exp,
		input string what);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("ERROR at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// Bus levels held for two clocks and outputs sampled on the falling edge
	task automatic hold_bus(input zx_bus_pkg::cpu_bus_t b);
		@(posedge clk_sys);
		bus <= b;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic io_write(input zx_bus_pkg::cpu_addr_t addr, input zx_bus_pkg::byte_t d);
		hold_bus(bus_of(addr, d, 1'b0, 1'b1, 1'b0, 1'b1));
		hold_bus(bus_of(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0));
	endtask

	task automatic io_read(input zx_bus_pkg::cpu_addr_t addr);
		hold_bus(bus_of(addr, 8'h00, 1'b0, 1'b1, 1'b1, 1'b0));
	endtask

	task automatic expect_bank(input logic [1:0] slot, input int bank, input string what);
		zx_bus_pkg::cpu_addr_t addr;
		addr = {slot, 14'($urandom)};
		hold_bus(bus_of(addr, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0));
		check_equal(ram.addr, bank_addr(bank, addr), what);
		check_equal(24'(ram.rd), 24'd1, {what, ", read strobe"});
	endtask

	task automatic expect_rom(input int page, input string what);
		zx_bus_pkg::cpu_addr_t addr;
		addr = {2'd0, 14'($urandom)};
		hold_bus(bus_of(addr, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0));
		check_equal(ram.addr, rom_addr(page, addr), what);
	endtask

	task automatic expect_we(input zx_bus_pkg::cpu_addr_t addr, input logic exp,
		input string what);
		hold_bus(bus_of(addr, 8'($urandom), 1'b1, 1'b0, 1'b0, 1'b1));
		check_equal(24'(ram.we), 24'(exp), what);
	endtask

	task automatic apply_reset(input zx_bus_pkg::zx_cfg_t c);
		int cycles;
		if (timed_out) return;
		@(posedge clk_sys);
		cfg       <= c;
		bus       <= bus_of(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0);
		reset_req <= 1'b1;
		@(posedge clk_sys);
		reset_req <= 1'b0;
		cycles = 0;
		do begin
			@(negedge clk_sys);
			cycles++;
			check_equal(24'({ram.rd, ram.we}), 24'd0, "strobes on idle bus");
		end while (reset && cycles < RESET_TIMEOUT);
		if (reset) begin
			timed_out = 1'b1;
			$display("Reset did not release within %0d cycles", RESET_TIMEOUT);
		end
	endtask

	// ============================================================
	// Tests
	// ============================================================
	task automatic test_128k_paging();
		zx_bus_pkg::byte_t d;
		apply_reset(cfg_of(zx_bus_pkg::MEM_128, zx_bus_pkg::JOY_SINCLAIR1,
			zx_bus_pkg::JOY_SINCLAIR2));
		if (timed_out) return;
		d = 8'($urandom) & 8'hDF;
		io_write(16'h7FFD, d);
		expect_rom(6 + int'(d[4]), "128K ROM bank");
		expect_bank(2'd1, 5, "128K slot 1");
		expect_bank(2'd2, 2, "128K slot 2");
		expect_bank(2'd3, int'(d[2:0]), "128K slot 3");
		io_write(16'h7FFD, d | 8'h20);  // Lock bit
		io_write(16'h7FFD, d ^ 8'h17);
		expect_bank(2'd3, int'(d[2:0]), "128K slot 3 after lock");
		expect_rom(6 + int'(d[4]), "128K ROM bank after lock");
	endtask

	task automatic test_48k_mode();
		apply_reset(cfg_of(zx_bus_pkg::MEM_48, zx_bus_pkg::JOY_SINCLAIR1,
			zx_bus_pkg::JOY_SINCLAIR2));
		if (timed_out) return;
		io_write(16'h7FFD, 8'h17);
		expect_rom(15, "48K ROM bank");
		expect_bank(2'd3, 0, "48K slot 3");
		expect_we({2'd0, 14'($urandom)}, 1'b0, "48K ROM write");
		expect_we({2'd2, 14'($urandom)}, 1'b1, "48K RAM write");
	endtask

	task automatic test_plus3_special();
		int cfg_bits;
		int slot;
		apply_reset(cfg_of(zx_bus_pkg::MEM_PLUS3, zx_bus_pkg::JOY_SINCLAIR1,
			zx_bus_pkg::JOY_SINCLAIR2));
		if (timed_out) return;
		io_write(16'h1FFD, 8'h04);
		io_write(16'h7FFD, 8'h10);
		expect_rom(11, "+3 ROM bank");
		for (cfg_bits = 0; cfg_bits < 4; cfg_bits++) begin
			io_write(16'h1FFD, 8'(cfg_bits * 2 + 1));
			for (slot = 0; slot < 4; slot++) begin
				expect_bank(2'(slot), SPECIAL_BANKS[cfg_bits][slot],
					$sformatf("+3 layout %0d slot %0d", cfg_bits, slot));
			end
			expect_we({2'd0, 14'($urandom)}, 1'b1, "+3 special write in slot 0");
		end
	endtask

	task automatic test_pentagon_1024();
		zx_bus_pkg::byte_t d;
		zx_bus_pkg::byte_t d2;
		apply_reset(cfg_of(zx_bus_pkg::MEM_P1024, zx_bus_pkg::JOY_SINCLAIR1,
			zx_bus_pkg::JOY_SINCLAIR2));
		if (timed_out) return;
		d = 8'($urandom) | 8'h20;  // Bit 5 does not lock while EFF7[2] is clear
		io_write(16'h7FFD, d);
		expect_bank(2'd3, ext_bank(d, d), "P1024 extended bank");
		expect_rom(6 + int'(d[4]), "P1024 ROM bank");
		d2 = 8'($urandom) & 8'hDF;
		io_write(16'h7FFD, d2);
		expect_bank(2'd3, ext_bank(d2, d2), "P1024 second bank");
		io_write(16'hEFF7, 8'h04);
		d = 8'($urandom) | 8'h20;
		io_write(16'h7FFD, d);
		expect_bank(2'd3, ext_bank(d2, d), "P1024 bank after EFF7");
		io_write(16'h7FFD, ~d);
		expect_bank(2'd3, ext_bank(d2, d), "P1024 locked bank");
	endtask

	task automatic test_port_fe();
		zx_bus_pkg::zx_cfg_t   c;
		zx_bus_pkg::cpu_addr_t addr;
		zx_bus_pkg::byte_t     d;
		zx_bus_pkg::byte_t     exp;
		int                    round;
		int                    i;
		for (round = 0; round < 4; round++) begin
			c = cfg_of(zx_bus_pkg::MEM_128, zx_bus_pkg::joy_mode_e'(2'($urandom)),
				zx_bus_pkg::joy_mode_e'(2'($urandom)));
			apply_reset(c);
			if (timed_out) return;
			d = 8'($urandom);
			io_write({8'($urandom), 8'hFE}, d);
			check_equal(24'(border), 24'(d[2:0]), "border");
			check_equal(24'(ear), 24'(d[4]), "EAR");
			check_equal(24'(mic), 24'(d[3]), "MIC");
			for (i = 0; i < 8; i++) begin
				@(posedge clk_sys);
				key_data <= 5'($urandom);
				joy0     <= 6'($urandom);
				joy1     <= 6'($urandom);
				tape_in  <= 1'($urandom);
				addr = {8'($urandom), 8'hFE};
				io_read(addr);
				exp = fe_expected(addr, key_data, joy0, joy1, c.joy0_mode, c.joy1_mode,
					tape_in | d[4]);
				check_equal(24'(cpu_din), 24'(exp), "FE read byte");
			end
		end
	endtask

	task automatic test_kempston_mux();
		zx_bus_pkg::zx_cfg_t c;
		zx_bus_pkg::byte_t   exp;
		c = cfg_of(zx_bus_pkg::MEM_128, zx_bus_pkg::JOY_KEMPSTON,
			zx_bus_pkg::joy_mode_e'(2'($urandom)));
		apply_reset(c);
		if (timed_out) return;
		@(posedge clk_sys);
		joy0     <= 6'($urandom);
		joy1     <= 6'($urandom);
		ram_dout <= 8'($urandom);
		io_read({8'($urandom), 8'h1F});
		exp = {2'b00, joy_in_mode(c.joy0_mode, joy0, c.joy1_mode, joy1,
			zx_bus_pkg::JOY_KEMPSTON)};
		check_equal(24'(cpu_din), 24'(exp), "Kempston byte");
		io_read({8'($urandom), 8'h3B});
		check_equal(24'(cpu_din), 24'hFF, "unused odd port");
		hold_bus(bus_of(16'($urandom), 8'h00, 1'b1, 1'b0, 1'b1, 1'b0));
		check_equal(24'(cpu_din), 24'(ram_dout), "memory read data");
	endtask

	initial begin
		void'($urandom(49709));
		checks    = 0;
		errors    = 0;
		timed_out = 1'b0;
		reset_req = 1'b0;
		bus       = bus_of(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0);
		cfg       = cfg_of(zx_bus_pkg::MEM_128, zx_bus_pkg::JOY_SINCLAIR1,
			zx_bus_pkg::JOY_SINCLAIR2);
		ram_dout  = 8'h00;
		key_data  = 5'h1F;  // No key pressed
		joy0      = 6'd0;
		joy1      = 6'd0;
		tape_in   = 1'b0;

		test_128k_paging();
		test_48k_mode();
		test_plus3_special();
		test_pentagon_1024();
		test_port_fe();
		test_kempston_mux();

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, int'(timed_out));
		if (!timed_out && errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* zx_bus_ctrl.f */
logic/zx_bus_pkg.sv
logic/zx_pager.sv
logic/zx_input_ports.sv
logic/zx_bus_map.sv
logic/zx_bus_ctrl.sv
bench/zx_clock_gen.sv
bench/zx_bus_ctrl_tb.sv

/* Makefile */
# Verilator build and run of the zx_bus_ctrl testbench

VERILATOR ?= verilator
TOP       ?= zx_bus_ctrl_tb
FILELIST  ?= zx_bus_ctrl.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
